/* preload_defines.svh */
`ifndef PRELOAD_DEFINES_SVH
`define PRELOAD_DEFINES_SVH

// L2 store geometry for the boot ROM image
// Eight 64-byte lines hold the 128-word ROM

// Number of cache lines in the store
`define PRELOAD_NUM_LINES 8

// 32-bit words per cache line
`define PRELOAD_LINE_WORDS 16

// Value read back from a word that was never loaded
// Encodes ADDI x30, x0, 0x666, so a stray fetch is easy to spot in a trace
`define PRELOAD_FILL_WORD 32'h66600f13

`endif

/* preloadPkg.sv */
`default_nettype none

`include "preload_defines.svh"

package preloadPkg;

    // Address split widths
    localparam int LINE_IDX_W = $clog2(`PRELOAD_NUM_LINES);
    localparam int WORD_OFS_W = $clog2(`PRELOAD_LINE_WORDS);
    // Byte offset bits inside one line
    localparam int LINE_OFS_W = WORD_OFS_W + 2;

    // One preload record, byte address plus instruction word
    // Address bit 0 set marks the stop sentinel
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } tPreloadRec;

    // Full line write from the assembler into the L2 store
    typedef struct packed {
        logic [LINE_IDX_W-1:0]                lineIdx;
        logic [`PRELOAD_LINE_WORDS-1:0][31:0] data;
        logic [`PRELOAD_LINE_WORDS-1:0]       mask;
    } tLineWrite;

    // Instruction fetch request and response
    typedef struct packed {
        logic [31:0] addr;
    } tFetchReq;

    typedef struct packed {
        logic [31:0] data;
    } tFetchRsp;

    // Line assembler states
    typedef enum logic [2:0] {
        IDLE,
        COLLECT,
        FLUSH,
        FINAL_FLUSH,
        DONE
    } tAsmState;

    // Line index of a byte address, upper bits beyond the store dropped
    function automatic logic [LINE_IDX_W-1:0] addrLine(logic [31:0] addr);
        return addr[LINE_OFS_W +: LINE_IDX_W];
    endfunction

    // Word offset inside the line, bits 1:0 dropped
    function automatic logic [WORD_OFS_W-1:0] addrWord(logic [31:0] addr);
        return addr[2 +: WORD_OFS_W];
    endfunction

endpackage

`default_nettype wire

/* lineAssembler.sv */
`default_nettype none

`include "preload_defines.svh"

module lineAssembler (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   recValid,
    output logic                   recReady,
    input  preloadPkg::tPreloadRec rec,
    output logic                   lineWrEn,
    output preloadPkg::tLineWrite  lineWr,
    output logic                   preloadDone
);
    import preloadPkg::*;

    tAsmState state;

    // Open line being gathered
    logic [LINE_IDX_W-1:0]                openIdx;
    logic [`PRELOAD_LINE_WORDS-1:0][31:0] lineBuf;
    logic [`PRELOAD_LINE_WORDS-1:0]       lineMask;

    // Low for the first cycle out of reset
    logic armed;

    // Decoded incoming record
    logic [LINE_IDX_W-1:0] recLine;
    logic [WORD_OFS_W-1:0] recWord;
    logic                  isSentinel;
    logic                  sameLine;
    logic                  recAccept;

    assign recLine    = addrLine(rec.addr);
    assign recWord    = addrWord(rec.addr);
    // Real word addresses are even
    assign isSentinel = rec.addr[0];
    assign sameLine   = (recLine == openIdx);

    // Ready rule
    // IDLE has no open line, so any record is taken
    // COLLECT stalls a record that would open another line
    always_comb begin
        case (state)
            IDLE:    recReady = armed;
            COLLECT: recReady = !(recValid && !isSentinel && !sameLine);
            default: recReady = 1'b0;
        endcase
    end

    assign recAccept = recValid && recReady;

    // Write out the open line in FLUSH and FINAL_FLUSH
    // Empty line after a bare sentinel is skipped
    assign lineWrEn = ((state == FLUSH) || (state == FINAL_FLUSH)) && (|lineMask);

    assign lineWr.lineIdx = openIdx;
    assign lineWr.data    = lineBuf;
    assign lineWr.mask    = lineMask;

    assign preloadDone = (state == DONE);

    // Control FSM
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            armed    <= 1'b0;
            openIdx  <= '0;
            lineMask <= '0;
        end else begin
            armed <= 1'b1;
            case (state)
                IDLE, COLLECT: begin
                    if (recAccept && isSentinel) begin
                        state <= FINAL_FLUSH;
                    end else if (recAccept) begin
                        // Opens the line in IDLE and keeps the same index in COLLECT
                        openIdx           <= recLine;
                        lineMask[recWord] <= 1'b1;
                        state             <= COLLECT;
                    end else if (recValid && (state == COLLECT)) begin
                        // Record for another line waits while the open one goes out
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    // Stalled record is taken next cycle from IDLE
                    lineMask <= '0;
                    state    <= IDLE;
                end
                FINAL_FLUSH: begin
                    lineMask <= '0;
                    state    <= DONE;
                end
                default: begin
                    // DONE holds until reset
                    state <= DONE;
                end
            endcase
        end
    end

    // Word buffer where a repeated address overwrites in place
    always_ff @(posedge clk) begin
        if (recAccept && !isSentinel) begin
            lineBuf[recWord] <= rec.data;
        end
    end

    // A flush for a new record always has words to write
    // The mask gate only drops the empty line of a bare sentinel
    assert property (@(posedge clk) disable iff (!rstN)
        (state == FLUSH) |-> lineWrEn);

    // Once done, no record is taken and done never drops
    assert property (@(posedge clk) disable iff (!rstN)
        preloadDone |=> (preloadDone && !recReady));

endmodule

`default_nettype wire

/* l2LineStore.sv */
`default_nettype none

`include "preload_defines.svh"

module l2LineStore (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                lineWrEn,
    input  preloadPkg::tLineWrite               lineWr,
    input  logic [preloadPkg::LINE_IDX_W-1:0]   rdLineIdx,
    input  logic [preloadPkg::WORD_OFS_W-1:0]   rdWordOfs,
    output logic [31:0]                         rdData
);

    // Line data, contents undefined until written
    logic [`PRELOAD_LINE_WORDS-1:0][31:0] lineData [`PRELOAD_NUM_LINES];

    // Per-word written flags, one vector per line
    logic [`PRELOAD_LINE_WORDS-1:0] wrMask [`PRELOAD_NUM_LINES];

    logic        rdHit;
    logic [31:0] rdWord;

    // Masked merge
    // Unmasked words keep what an earlier load left
    always_ff @(posedge clk) begin
        if (lineWrEn) begin
            for (int w = 0; w < `PRELOAD_LINE_WORDS; w++) begin
                if (lineWr.mask[w]) begin
                    lineData[lineWr.lineIdx][w] <= lineWr.data[w];
                end
            end
        end
    end

    // Written flags accumulate across loads of the same line
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int l = 0; l < `PRELOAD_NUM_LINES; l++) begin
                wrMask[l] <= '0;
            end
        end else if (lineWrEn) begin
            wrMask[lineWr.lineIdx] <= wrMask[lineWr.lineIdx] | lineWr.mask;
        end
    end

    // Combinational word read
    assign rdHit  = wrMask[rdLineIdx][rdWordOfs];
    assign rdWord = lineData[rdLineIdx][rdWordOfs];

    // Never-written words return the fill instruction
    assign rdData = rdHit ? rdWord : `PRELOAD_FILL_WORD;

    // Line index from the assembler must land inside the array
    assert property (@(posedge clk) disable iff (!rstN)
        lineWrEn |-> (!$isunknown(lineWr.lineIdx)
                      && (int'(lineWr.lineIdx) < `PRELOAD_NUM_LINES)));

endmodule

`default_nettype wire

/* fetchReader.sv */
`default_nettype none

module fetchReader (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                preloadDone,
    input  logic                                fetchValid,
    output logic                                fetchReady,
    input  preloadPkg::tFetchReq                fetchReq,
    output logic                                rspValid,
    input  logic                                rspReady,
    output preloadPkg::tFetchRsp                rsp,
    output logic [preloadPkg::LINE_IDX_W-1:0]   rdLineIdx,
    output logic [preloadPkg::WORD_OFS_W-1:0]   rdWordOfs,
    input  logic [31:0]                         rdData
);
    import preloadPkg::*;

    logic fetchAccept;

    // Byte address to store coordinates
    // Bits 1:0 and anything above the store are dropped
    assign rdLineIdx = addrLine(fetchReq.addr);
    assign rdWordOfs = addrWord(fetchReq.addr);

    // Take a request only after preload, and only when the
    // response slot is free or drains this same cycle
    assign fetchReady  = preloadDone && (!rspValid || rspReady);
    assign fetchAccept = fetchValid && fetchReady;

    // Response valid flag
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rspValid <= 1'b0;
        end else if (fetchAccept) begin
            // Valid one cycle after acceptance
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    // Response payload
    // Loaded only on acceptance, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (fetchAccept) begin
            rsp.data <= rdData;
        end
    end

    // Stalled response keeps value and valid
    assert property (@(posedge clk) disable iff (!rstN)
        (rspValid && !rspReady) |=> (rspValid && $stable(rsp)));

    // No fetch slips in ahead of the assembler finishing
    // No response can be pending before preload is done
    assert property (@(posedge clk) disable iff (!rstN)
        !preloadDone |-> !rspValid);

endmodule

`default_nettype wire

/* preloadTop.sv */
`default_nettype none

module preloadTop (
    input  logic                   clk,
    input  logic                   rstN,
    // Preload record stream
    input  logic                   recValid,
    output logic                   recReady,
    input  preloadPkg::tPreloadRec rec,
    output logic                   preloadDone,
    // Instruction fetch port
    input  logic                   fetchValid,
    output logic                   fetchReady,
    input  preloadPkg::tFetchReq   fetchReq,
    output logic                   rspValid,
    input  logic                   rspReady,
    output preloadPkg::tFetchRsp   rsp
);
    import preloadPkg::*;

    // Assembler to store
    logic      lineWrEn;
    tLineWrite lineWr;

    // Reader to store
    logic [LINE_IDX_W-1:0] rdLineIdx;
    logic [WORD_OFS_W-1:0] rdWordOfs;
    logic [31:0]           rdData;

    // Packs records into lines
    lineAssembler iAsm (
        .clk         (clk),
        .rstN        (rstN),
        .recValid    (recValid),
        .recReady    (recReady),
        .rec         (rec),
        .lineWrEn    (lineWrEn),
        .lineWr      (lineWr),
        .preloadDone (preloadDone)
    );

    // L2 line array
    l2LineStore iStore (
        .clk       (clk),
        .rstN      (rstN),
        .lineWrEn  (lineWrEn),
        .lineWr    (lineWr),
        .rdLineIdx (rdLineIdx),
        .rdWordOfs (rdWordOfs),
        .rdData    (rdData)
    );

    // Word fetch, opened by preloadDone
    fetchReader iReader (
        .clk         (clk),
        .rstN        (rstN),
        .preloadDone (preloadDone),
        .fetchValid  (fetchValid),
        .fetchReady  (fetchReady),
        .fetchReq    (fetchReq),
        .rspValid    (rspValid),
        .rspReady    (rspReady),
        .rsp         (rsp),
        .rdLineIdx   (rdLineIdx),
        .rdWordOfs   (rdWordOfs),
        .rdData      (rdData)
    );

endmodule

`default_nettype wire

/* tbPreloadChecker.sv */
`default_nettype none

`include "preload_defines.svh"

module tbPreloadChecker (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   recValid,
    input  logic                   recReady,
    input  preloadPkg::tPreloadRec rec,
    input  logic                   preloadDone,
    input  logic                   fetchValid,
    input  logic                   fetchReady,
    input  preloadPkg::tFetchReq   fetchReq,
    input  logic                   rspValid,
    input  logic                   rspReady,
    input  preloadPkg::tFetchRsp   rsp,
    input  logic                   endRun,
    output int                     errCount,
    output int                     checkCount
);
    timeunit 1ns;
    timeprecision 100ps;

    import preloadPkg::*;

    localparam int MODEL_WORDS = `PRELOAD_NUM_LINES * `PRELOAD_LINE_WORDS;
    localparam int IDX_W       = $clog2(MODEL_WORDS);

    // Reference ROM image, one entry per 32-bit word
    logic [31:0]      model [MODEL_WORDS];
    // Word indexes of accepted fetches still waiting for a response
    logic [IDX_W-1:0] pendQ [$];

    logic        sentinelSeen;
    logic        doneSeen;
    logic        lastAccept;
    logic        lastStall;
    logic        finalDone;
    logic [31:0] lastRsp;
    logic [IDX_W-1:0] idx;

    // Word index of a byte address, bits 1:0 and bits above the ROM dropped
    function automatic logic [IDX_W-1:0] wordIndex(input logic [31:0] addr);
        return addr[2 +: IDX_W];
    endfunction

    task automatic countError(input string msg);
        $display("%s", msg);
        errCount++;
    endtask

    // Everything sampled at the rising edge, before the DUT flops update
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < MODEL_WORDS; i++) begin
                model[i] = `PRELOAD_FILL_WORD;
            end
            pendQ.delete();
            errCount     = 0;
            checkCount   = 0;
            sentinelSeen = 1'b0;
            doneSeen     = 1'b0;
            lastAccept   = 1'b0;
            lastStall    = 1'b0;
            finalDone    = 1'b0;
            lastRsp      = '0;
        end else begin
            // Preload handshake rules
            if (doneSeen && !preloadDone)
                countError("preloadDone fell after it had risen");
            if (preloadDone && !sentinelSeen)
                countError("preloadDone rose before the sentinel was accepted");
            if (preloadDone && recReady)
                countError("recReady was high after preloadDone");
            if (!preloadDone && fetchReady)
                countError("fetchReady was high before preloadDone");
            if (preloadDone)
                doneSeen = 1'b1;

            // Accepted record updates the model, last write wins
            if (recValid && recReady) begin
                if (rec.addr[0])
                    sentinelSeen = 1'b1;
                else
                    model[wordIndex(rec.addr)] = rec.data;
            end

            // Response timing against the previous cycle
            if (lastAccept && !rspValid)
                countError("rspValid did not rise one cycle after a fetch was accepted");
            if (rspValid && !lastAccept && !lastStall)
                countError("rspValid rose with no accepted fetch behind it");
            if (lastStall && (rsp.data !== lastRsp))
                countError($sformatf("[FAIL] rsp.data moved under back-pressure: 0x%08h -> 0x%08h",
                                     lastRsp, rsp.data));
            if (rspValid && !rspReady && fetchReady)
                countError("fetchReady was high while the response was stalled");

            // Drain before push, the response belongs to an older request
            if (rspValid && rspReady) begin
                if (pendQ.size() == 0) begin
                    countError("a response arrived with no pending fetch");
                end else begin
                    idx = pendQ.pop_front();
                    checkCount++;
                    if (rsp.data !== model[idx])
                        countError($sformatf("[FAIL] rsp.data at 0x%03h: got 0x%08h expected 0x%08h",
                                             {idx, 2'b00}, rsp.data, model[idx]));
                end
            end
            if (fetchValid && fetchReady)
                pendQ.push_back(wordIndex(fetchReq.addr));

            lastAccept = fetchValid && fetchReady;
            lastStall  = rspValid && !rspReady;
            lastRsp    = rsp.data;

            // End of run bookkeeping
            if (endRun && !finalDone) begin
                finalDone = 1'b1;
                if (pendQ.size() != 0)
                    countError($sformatf("%0d accepted fetches never got a response",
                                         pendQ.size()));
                if (!doneSeen)
                    countError("preloadDone never rose");
                if (checkCount == 0)
                    countError("no fetch response was checked");
            end
        end
    end

endmodule

`default_nettype wire

/* tbPreload.sv */
`default_nettype none

`include "preload_defines.svh"

module tbPreload;
    timeunit 1ns;
    timeprecision 100ps;

    import preloadPkg::*;

    localparam int NUM_RECORDS = 150;
    localparam int NUM_FETCHES = 300;
    // Roughly four times the expected length of both phases
    localparam int MAX_CYCLES  = 4 * (NUM_RECORDS + NUM_FETCHES + 50);
    localparam int LINE_BITS   = $clog2(`PRELOAD_NUM_LINES);
    localparam int WORD_BITS   = $clog2(`PRELOAD_LINE_WORDS);
    localparam logic [31:0] SEED = 32'h57436a6d;

    logic        clk;
    logic        rstN;
    logic        recValid;
    logic        recReady;
    tPreloadRec  rec;
    logic        preloadDone;
    logic        fetchValid;
    logic        fetchReady;
    tFetchReq    fetchReq;
    logic        rspValid;
    logic        rspReady;
    tFetchRsp    rsp;
    logic        endRun;
    int          errCount;
    int          checkCount;
    int          cycleCount;
    logic [31:0] lfsrState;

    preloadTop i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .recValid    (recValid),
        .recReady    (recReady),
        .rec         (rec),
        .preloadDone (preloadDone),
        .fetchValid  (fetchValid),
        .fetchReady  (fetchReady),
        .fetchReq    (fetchReq),
        .rspValid    (rspValid),
        .rspReady    (rspReady),
        .rsp         (rsp)
    );

    tbPreloadChecker scoreboard (
        .clk (clk), .rstN (rstN),
        .recValid (recValid), .recReady (recReady), .rec (rec),
        .preloadDone (preloadDone),
        .fetchValid (fetchValid), .fetchReady (fetchReady), .fetchReq (fetchReq),
        .rspValid (rspValid), .rspReady (rspReady), .rsp (rsp),
        .endRun (endRun), .errCount (errCount), .checkCount (checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    // Entered and left on a falling edge
    task automatic sendRecord(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] gap;
        takeBits(2, gap);
        if (gap == 0) begin
            recValid = 1'b0;
            @(negedge clk);
        end
        recValid = 1'b1;
        rec.addr = addr;
        rec.data = data;
        @(posedge clk);
        while (!recReady) @(posedge clk);
        @(negedge clk);
        recValid = 1'b0;
    endtask

    // Runs inside a line, jumps between lines, repeats of one address
    task automatic loadPhase();
        logic [31:0] sel;
        logic [31:0] line;
        logic [31:0] ofs;
        logic [31:0] data;
        line = '0;
        ofs  = '0;
        for (int n = 0; n < NUM_RECORDS; n++) begin
            takeBits(3, sel);
            // sel of zero keeps the previous address
            if (sel != 0) begin
                if (sel > 4)
                    takeBits(LINE_BITS, line);
                takeBits(WORD_BITS, ofs);
            end
            takeBits(32, data);
            sendRecord((line << (WORD_BITS + 2)) | (ofs << 2), data);
        end
        // Odd address ends the stream
        sendRecord(32'h1, 32'h0);
        while (!preloadDone) @(negedge clk);
    endtask

    // One iteration per clock, rspReady low about a quarter of the time
    task automatic fetchPhase();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] hi;
        logic        accepted;
        int          sent;
        sent = 0;
        while (sent < NUM_FETCHES) begin
            takeBits(2, r);
            rspReady = (r != 0);
            if (!fetchValid) begin
                takeBits(2, r);
                if (r != 0) begin
                    // Bit 1 and high bits are don't-care for the store
                    takeBits(9, a);
                    takeBits(3, hi);
                    fetchReq.addr = (a & 32'h1fe) | (hi << 29);
                    fetchValid    = 1'b1;
                end
            end
            @(posedge clk);
            accepted = fetchValid && fetchReady;
            if (accepted)
                sent++;
            @(negedge clk);
            if (accepted)
                fetchValid = 1'b0;
        end
        rspReady = 1'b1;
        while (rspValid) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    initial begin
        lfsrState = SEED;
        rstN      = 1'b0;
        recValid  = 1'b0;
        rec       = '0;
        fetchValid = 1'b0;
        fetchReq  = '0;
        rspReady  = 1'b0;
        endRun    = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        loadPhase();
        fetchPhase();
        // Let the checker run its end-of-run checks
        endRun = 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("Closing: %0d responses checked, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Hang guard
    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run hung and did not finish within %0d cycles", MAX_CYCLES);
        $display("Closing: %0d responses checked, %0d errors", checkCount, errCount + 1);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
preloadPkg.sv
lineAssembler.sv
l2LineStore.sv
fetchReader.sv
preloadTop.sv
tbPreloadChecker.sv
tbPreload.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the preload testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module tbPreload -o simPreload

./obj_dir/simPreload | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
